// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing
TOP       := calculator_tb
FILELIST  := filelist.f
BUILD_DIR := obj_dir
PASS_MSG  := Test completed successfully

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
		echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: bench/calc_input.txt
2 12 2 34 001 002e 0
4 1234 4 5678 001 1b00 0
4 9999 4 9999 001 4e1e 0
4 5000 4 1234 010 0eb6 0
2 12 3 345 010 feb3 0
1 0 4 9999 010 d8f1 0
2 12 2 34 100 0198 0
4 9999 4 9999 100 92e1 0
3 255 3 257 100 ffff 0
3 256 3 256 100 0000 0
6 123456 2 78 001 0520 0
5 99999 1 2 100 4e1e 0
3 800 2 25 010 0307 1
4 4321 4 1111 001 1538 1
3 123 2 45 100 159f 1
4 0042 4 0008 001 0032 0
3 777 3 777 010 0000 0
1 7 1 0 001 0007 0
4 1000 2 65 100 fde8 0
1 1 5 99999 010 d8f2 0

// File: bench/calculator_tb.sv
`timescale 1ns/1ps
`default_nettype none

module calculator_tb
    import calc_pkg::*;
();

    localparam int       CLK_PERIOD   = 20;
    localparam int       RESET_CYCLES = 16;
    localparam int       LINE_CYCLES  = 60;        // Budget per calculation
    localparam int       ADD_LATENCY  = 3;         // Equal to complete for add and subtract
    localparam string    INPUT_FILE   = "bench/calc_input.txt";
    localparam calc_op_e NO_OP        = calc_op_e'(3'b000);

    logic                  clk;
    logic                  nRST;
    digit_t                keypad_input;
    logic                  read_input;
    calc_op_e              operator_input;
    logic                  equal_input;
    logic                  complete;
    logic [CALC_WIDTH-1:0] display_output;

    // One entry per calculation line
    int unsigned           a_len_q[$];
    logic [31:0]           a_digits_q[$];
    int unsigned           b_len_q[$];
    logic [31:0]           b_digits_q[$];
    calc_op_e              op_q[$];
    logic [CALC_WIDTH-1:0] expected_q[$];
    bit                    inject_q[$];

    bit                    vectors_loaded;
    bit                    waiting;                // Complete allowed inside a calculation

    calculator_top #(
        .MAX_DIGITS (4)
    ) u_calculator_top (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .complete       (complete),
        .display_output (display_output)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("Controller state %s", u_calculator_top.u_calc_control.state.name());
            $display("Test failed");
            $fatal(1, "value check on %s", name);
        end
    endtask

    task automatic load_vectors;
        int          fd;
        int          code;
        int unsigned a_len;
        int unsigned b_len;
        int unsigned flag;
        logic [31:0] a_digits;
        logic [31:0] b_digits;
        logic [2:0]  op;
        logic [15:0] expected;
        fd = $fopen(INPUT_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file %s", INPUT_FILE);
            $display("Test failed");
            $fatal(1, "missing stimulus file");
        end
        code = $fscanf(fd, "%d %h %d %h %b %h %d\n",
                       a_len, a_digits, b_len, b_digits, op, expected, flag);
        while (code == 7) begin
            a_len_q.push_back(a_len);
            a_digits_q.push_back(a_digits);
            b_len_q.push_back(b_len);
            b_digits_q.push_back(b_digits);
            op_q.push_back(calc_op_e'(op));
            expected_q.push_back(expected);
            inject_q.push_back(flag != 0);
            code = $fscanf(fd, "%d %h %d %h %b %h %d\n",
                           a_len, a_digits, b_len, b_digits, op, expected, flag);
        end
        $fclose(fd);
    endtask

    // Called and returns on a falling edge
    task automatic press_key(input digit_t key);
        int unsigned gap;
        keypad_input = key;
        read_input   = 1'b1;
        @(negedge clk);
        read_input = 1'b0;
        gap = $urandom % 4;                        // Idle cycles between keys
        repeat (gap) @(negedge clk);
    endtask

    // One digit per nibble with the first typed digit on top
    task automatic type_operand(input int unsigned len, input logic [31:0] digits,
                                input bit inject);
        int unsigned i;
        for (i = 0; i < len; i++) begin
            if (inject && i == 1) begin
                press_key(4'd12);                  // Not a decimal key
            end
            press_key(digit_t'(digits >> (4 * (len - 1 - i))));
        end
    endtask

    task automatic run_line(input int idx);
        int cycles;
        type_operand(a_len_q[idx], a_digits_q[idx], inject_q[idx]);
        operator_input = op_q[idx];
        @(negedge clk);
        operator_input = NO_OP;
        type_operand(b_len_q[idx], b_digits_q[idx], inject_q[idx]);
        equal_input = 1'b1;
        @(posedge clk);                            // Equal sampled here
        waiting = 1'b1;
        @(negedge clk);
        equal_input = 1'b0;
        cycles = 0;
        while (!complete) begin
            if (cycles > 4 * CALC_WIDTH) begin
                $display("No complete pulse after equal on line %0d", idx + 1);
                $display("Test failed");
                $fatal(1, "calculation never completed");
            end
            @(negedge clk);
            cycles++;
        end
        check_value("display_output", 32'(display_output), 32'(expected_q[idx]));
        if (op_q[idx] != OP_MUL) begin
            check_value("complete latency", 32'(cycles), 32'(ADD_LATENCY));
        end
        @(negedge clk);                            // Back in ENTER_A with operands cleared
        waiting = 1'b0;
        check_value("complete", 32'(complete), 32'd0);
    endtask

    // Complete may only pulse at the end of a calculation
    always @(negedge clk) begin
        if (nRST && !waiting) begin
            check_value("complete", 32'(complete), 32'd0);
        end
    end

    initial begin
        int limit;
        wait (vectors_loaded);
        limit = a_len_q.size() * LINE_CYCLES + RESET_CYCLES;
        repeat (limit) @(posedge clk);
        $display("The run timed out after %0d cycles", limit);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int idx;
        clk            = 1'b0;
        nRST           = 1'b0;
        keypad_input   = '0;
        read_input     = 1'b0;
        operator_input = NO_OP;
        equal_input    = 1'b0;
        waiting        = 1'b0;
        void'($urandom(32'h565c266a));
        load_vectors();
        if (a_len_q.size() == 0) begin
            $display("The stimulus file holds no calculations");
            $display("Test failed");
            $fatal(1, "empty stimulus");
        end
        vectors_loaded = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        nRST = 1'b1;
        @(negedge clk);
        check_value("display_output", 32'(display_output), 32'd0);    // Cleared by reset
        check_value("complete", 32'(complete), 32'd0);
        for (idx = 0; idx < a_len_q.size(); idx++) begin
            run_line(idx);
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: design/add_sub_unit.sv
`timescale 1ns/1ps
`default_nettype none

module add_sub_unit
    import calc_pkg::*;
(
    input  logic          clk,
    input  logic          nRST,
    input  logic          start,
    input  arith_req_t    req,
    output arith_result_t result
);

    logic [CALC_WIDTH-1:0] sum_q;
    logic                  pending;     // Finish follows one edge later
    logic                  finish_q;

    always_ff @(posedge clk) begin
        if (start) begin
            sum_q <= req.subtract ? req.operand_a - req.operand_b    // Wraps mod 2^16
                                  : req.operand_a + req.operand_b;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            pending  <= 1'b0;
            finish_q <= 1'b0;
        end else begin
            pending  <= start;
            finish_q <= pending;
        end
    end

    assign result = '{value: sum_q, finish: finish_q};

endmodule

`default_nettype wire

// File: design/calc_control.sv
`timescale 1ns/1ps
`default_nettype none

module calc_control
    import calc_pkg::*;
(
    input  logic                  clk,
    input  logic                  nRST,

    // Keypad side
    input  logic                  read_input,
    input  calc_op_e              operator_input,
    input  logic                  equal_input,

    // Operand accumulators
    input  logic [CALC_WIDTH-1:0] value_a,
    input  logic [CALC_WIDTH-1:0] value_b,
    output logic                  enable_a,
    output logic                  enable_b,
    output logic                  clear,

    // Arithmetic units
    input  arith_result_t         add_result,
    input  arith_result_t         mul_result,
    output logic                  start_add,
    output logic                  start_mul,
    output arith_req_t            req,

    // Display side
    output logic                  complete,
    output logic [CALC_WIDTH-1:0] display_output
);

    calc_state_e   state;
    calc_state_e   state_next;
    calc_op_e      op_q;            // Operator latched in ENTER_A
    logic          op_valid;
    logic          mul_selected;
    arith_result_t unit_result;     // Result of the launched unit

    // Only a proper one-hot code counts as an operator
    always_comb begin
        case (operator_input)
            OP_ADD, OP_SUB, OP_MUL: op_valid = 1'b1;
            default:                op_valid = 1'b0;
        endcase
    end

    assign mul_selected = (op_q == OP_MUL);
    assign unit_result  = mul_selected ? mul_result : add_result;

    // Next state
    always_comb begin
        state_next = state;
        case (state)
            ENTER_A: begin
                if (op_valid) begin
                    state_next = ENTER_B;
                end
            end
            ENTER_B: begin
                if (equal_input) begin
                    state_next = LAUNCH;
                end
            end
            LAUNCH: begin
                state_next = WAIT_UNIT;    // Start pulse lasts this one cycle
            end
            WAIT_UNIT: begin
                if (unit_result.finish) begin
                    state_next = SHOW;
                end
            end
            SHOW: begin
                state_next = ENTER_A;
            end
            default: begin
                state_next = ENTER_A;
            end
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state <= ENTER_A;
        end else begin
            state <= state_next;
        end
    end

    // Operator register
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            op_q <= OP_ADD;
        end else if (state == ENTER_A && op_valid) begin
            op_q <= operator_input;
        end
    end

    // Display holds until the next result
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            display_output <= '0;
        end else if (state == WAIT_UNIT && unit_result.finish) begin
            display_output <= unit_result.value;
        end
    end

    // Digit strobes go to whichever operand is being typed
    assign enable_a = read_input && (state == ENTER_A);
    assign enable_b = read_input && (state == ENTER_B);

    assign req = '{
        operand_a: value_a,
        operand_b: value_b,
        subtract:  (op_q == OP_SUB)
    };

    assign start_add = (state == LAUNCH) && !mul_selected;
    assign start_mul = (state == LAUNCH) && mul_selected;

    // SHOW lasts one cycle, so both are single pulses
    assign complete = (state == SHOW);
    assign clear    = (state == SHOW);    // Operands start fresh after each result

endmodule

`default_nettype wire

// File: design/calc_pkg.sv
`default_nettype none

package calc_pkg;

    // Operand and result width
    parameter int CALC_WIDTH = 16;

    typedef logic [3:0] digit_t;    // One keypad code

    // One-hot operator codes as presented on the keypad side
    typedef enum logic [2:0] {
        OP_ADD = 3'b001,
        OP_SUB = 3'b010,
        OP_MUL = 3'b100
    } calc_op_e;

    typedef enum logic [2:0] {
        ENTER_A   = 3'd0,           // Collecting first operand
        ENTER_B   = 3'd1,           // Collecting second operand
        LAUNCH    = 3'd2,           // Start pulse to one unit
        WAIT_UNIT = 3'd3,           // Waiting on unit finish
        SHOW      = 3'd4            // Result shown and operands cleared
    } calc_state_e;

    // Request from the controller to both units
    typedef struct packed {
        logic [CALC_WIDTH-1:0] operand_a;
        logic [CALC_WIDTH-1:0] operand_b;
        logic                  subtract;    // Only the adder looks at this
    } arith_req_t;

    // Result returned by each unit
    typedef struct packed {
        logic [CALC_WIDTH-1:0] value;
        logic                  finish;      // One-cycle pulse
    } arith_result_t;

endpackage

`default_nettype wire

// File: design/calculator_top.sv
`timescale 1ns/1ps
`default_nettype none

module calculator_top
    import calc_pkg::*;
#(
    parameter int MAX_DIGITS = 4      // 1 to 4 fits the 16-bit operands
) (
    input  logic                  clk,
    input  logic                  nRST,
    input  digit_t                keypad_input,
    input  logic                  read_input,
    input  calc_op_e              operator_input,
    input  logic                  equal_input,
    output logic                  complete,
    output logic [CALC_WIDTH-1:0] display_output
);

    logic [CALC_WIDTH-1:0] value_a;
    logic [CALC_WIDTH-1:0] value_b;
    logic                  enable_a;
    logic                  enable_b;
    logic                  clear;
    logic                  start_add;
    logic                  start_mul;
    arith_req_t            req;
    arith_result_t         add_result;
    arith_result_t         mul_result;

    calc_control u_calc_control (
        .clk            (clk),
        .nRST           (nRST),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .value_a        (value_a),
        .value_b        (value_b),
        .enable_a       (enable_a),
        .enable_b       (enable_b),
        .clear          (clear),
        .add_result     (add_result),
        .mul_result     (mul_result),
        .start_add      (start_add),
        .start_mul      (start_mul),
        .req            (req),
        .complete       (complete),
        .display_output (display_output)
    );

    digit_accumulator #(
        .MAX_DIGITS (MAX_DIGITS)
    ) u_operand_a (
        .clk    (clk),
        .nRST   (nRST),
        .enable (enable_a),
        .clear  (clear),
        .digit  (keypad_input),
        .value  (value_a)
    );

    digit_accumulator #(
        .MAX_DIGITS (MAX_DIGITS)
    ) u_operand_b (
        .clk    (clk),
        .nRST   (nRST),
        .enable (enable_b),
        .clear  (clear),
        .digit  (keypad_input),
        .value  (value_b)
    );

    add_sub_unit u_add_sub_unit (
        .clk    (clk),
        .nRST   (nRST),
        .start  (start_add),
        .req    (req),
        .result (add_result)
    );

    shift_add_multiplier u_shift_add_multiplier (
        .clk    (clk),
        .nRST   (nRST),
        .start  (start_mul),
        .req    (req),
        .result (mul_result)
    );

endmodule

`default_nettype wire

// File: design/digit_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module digit_accumulator
    import calc_pkg::*;
#(
    parameter int MAX_DIGITS = 4
) (
    input  logic                  clk,
    input  logic                  nRST,
    input  logic                  enable,
    input  logic                  clear,
    input  digit_t                digit,
    output logic [CALC_WIDTH-1:0] value
);

    localparam int COUNT_WIDTH = $clog2(MAX_DIGITS + 1);

    logic [COUNT_WIDTH-1:0] count;          // Digits taken so far
    logic                   digit_ok;
    logic [CALC_WIDTH-1:0]  digit_ext;
    logic [CALC_WIDTH-1:0]  value_next;

    assign digit_ok  = (digit <= digit_t'(9)) && (count < COUNT_WIDTH'(MAX_DIGITS));
    assign digit_ext = {{(CALC_WIDTH - $bits(digit_t)){1'b0}}, digit};

    // Times ten is times eight plus times two
    assign value_next = (value << 3) + (value << 1) + digit_ext;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            value <= '0;
            count <= '0;
        end else if (clear) begin        // Clear wins over a late digit
            value <= '0;
            count <= '0;
        end else if (enable && digit_ok) begin
            value <= value_next;
            count <= count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: design/shift_add_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module shift_add_multiplier
    import calc_pkg::*;
(
    input  logic          clk,
    input  logic          nRST,
    input  logic          start,
    input  arith_req_t    req,
    output arith_result_t result
);

    localparam int STEP_WIDTH = $clog2(CALC_WIDTH);

    logic [CALC_WIDTH-1:0] multiplicand;    // Shifts left each step
    logic [CALC_WIDTH-1:0] multiplier;      // Shifts right each step
    logic [CALC_WIDTH-1:0] product;
    logic [STEP_WIDTH-1:0] step;
    logic                  busy;
    logic                  finish_q;
    logic                  last_step;

    assign last_step = (step == STEP_WIDTH'(CALC_WIDTH - 1));

    // Bits above CALC_WIDTH fall off and leave the low half of the product
    always_ff @(posedge clk) begin
        if (start) begin
            multiplicand <= req.operand_a;
            multiplier   <= req.operand_b;
            product      <= '0;
        end else if (busy) begin
            if (multiplier[0]) begin
                product <= product + multiplicand;
            end
            multiplicand <= multiplicand << 1;
            multiplier   <= multiplier >> 1;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            step     <= '0;
            busy     <= 1'b0;
            finish_q <= 1'b0;
        end else begin
            finish_q <= 1'b0;
            if (start) begin
                step <= '0;
                busy <= 1'b1;
            end else if (busy) begin
                step <= step + 1'b1;
                if (last_step) begin        // CALC_WIDTH steps done
                    busy     <= 1'b0;
                    finish_q <= 1'b1;
                end
            end
        end
    end

    assign result = '{value: product, finish: finish_q};

endmodule

`default_nettype wire

// File: filelist.f
design/calc_pkg.sv
design/digit_accumulator.sv
design/add_sub_unit.sv
design/shift_add_multiplier.sv
design/calc_control.sv
design/calculator_top.sv
bench/calculator_tb.sv
